// ==== common/pixelIf.sv ====
interface pixelIf
    import vgaDemoPkg::*;
();

    logic [X_BITS-1:0]     x;
    logic [Y_BITS-1:0]     y;
    logic [COLOR_BITS-1:0] color;
    logic                  write;    // one pixel per cycle while high
    logic                  done;     // one-cycle end of a redraw

    // drawer side
    modport objectDrawer (output x, y, color, write, done);
    // arbiter side
    modport pixelArbiter (input x, y, color, write, done);

endinterface

// ==== common/vgaDemoPkg.sv ====
package vgaDemoPkg;

    localparam int X_BITS         = 10;    // 640 columns
    localparam int Y_BITS         = 9;     // 480 rows
    localparam int COLOR_BITS     = 9;     // rrrgggbbb
    localparam int SPRITE_BITS    = 4;     // sprite side is 1 << SPRITE_BITS
    localparam int PS2_FRAME_BITS = 11;    // start, 8 data, parity, stop

    localparam logic [7:0] BREAK_CODE = 8'hF0;    // key release prefix

    // move directions as the drawers decode them
    localparam logic [1:0] DIR_LEFT  = 2'b00;
    localparam logic [1:0] DIR_UP    = 2'b01;
    localparam logic [1:0] DIR_DOWN  = 2'b10;
    localparam logic [1:0] DIR_RIGHT = 2'b11;

    // object 1 keys a/s/w/z all have bit 4 set
    typedef struct packed {
        logic [2:0] rsvdHi;
        logic       objSel;    // 1 picks object 1
        logic [1:0] rsvdMid;
        logic [1:0] dir;       // already in DIR_* coding
    } obj1Key_t;

    // object 2 keys d/f/r/c carry the direction in bits 3 and 1
    typedef struct packed {
        logic [3:0] rsvdHi;
        logic       dirHi;
        logic       rsvdMid;
        logic       dirLo;
        logic       rsvdLo;
    } obj2Key_t;

    typedef union packed {
        logic [7:0] raw;
        obj1Key_t   obj1;
        obj2Key_t   obj2;
    } keyCode_u;

    typedef logic [2:0][7:0] frameBytes_t;    // [2] newest, [1] middle, [0] oldest

endpackage

// ==== hw/hexDisplay.sv ====
module hexDisplay
    import vgaDemoPkg::*;
(
    input  frameBytes_t frames,
    output logic [6:0]  hex0,
    output logic [6:0]  hex1,
    output logic [6:0]  hex2,
    output logic [6:0]  hex3,
    output logic [6:0]  hex4,
    output logic [6:0]  hex5
);

    // segments gfedcba, low lights the segment
    function automatic logic [6:0] seg7(input logic [3:0] nib);
        case (nib)
            4'h0: return 7'b1000000;
            4'h1: return 7'b1111001;
            4'h2: return 7'b0100100;
            4'h3: return 7'b0110000;
            4'h4: return 7'b0011001;
            4'h5: return 7'b0010010;
            4'h6: return 7'b0000010;
            4'h7: return 7'b1111000;
            4'h8: return 7'b0000000;
            4'h9: return 7'b0011000;
            4'hA: return 7'b0001000;
            4'hB: return 7'b0000011;
            4'hC: return 7'b1000110;
            4'hD: return 7'b0100001;
            4'hE: return 7'b0000110;
            default: return 7'b0001110;    // F
        endcase
    endfunction

    assign hex0 = seg7(frames[0][3:0]);    // oldest byte
    assign hex1 = seg7(frames[0][7:4]);
    assign hex2 = seg7(frames[1][3:0]);    // middle, F0 on a clean stroke
    assign hex3 = seg7(frames[1][7:4]);
    assign hex4 = seg7(frames[2][3:0]);    // newest byte
    assign hex5 = seg7(frames[2][7:4]);

endmodule

// ==== hw/pixelArbiter.sv ====
module pixelArbiter
    import vgaDemoPkg::*;
(
    input  logic                  CLOCK_50,
    input  logic                  rstN,
    input  logic [1:0]            show,
    input  logic [1:0]            move,
    pixelIf.pixelArbiter          obj1,
    pixelIf.pixelArbiter          obj2,
    output logic                  drawDone,
    output logic [X_BITS-1:0]     pixelX,
    output logic [Y_BITS-1:0]     pixelY,
    output logic [COLOR_BITS-1:0] pixelColor,
    output logic                  pixelWrite
);

    logic owner;    // 0 is object 1, 1 is object 2

    always_ff @(posedge CLOCK_50) begin
        if (!rstN || show[0]) begin
            owner <= 1'b0;
        end else if (show[1]) begin
            owner <= 1'b1;
        end else if (|move) begin
            owner <= move[1];    // move is one-hot
        end
    end

    // straight mux, no added latency
    assign pixelX     = owner ? obj2.x     : obj1.x;
    assign pixelY     = owner ? obj2.y     : obj1.y;
    assign pixelColor = owner ? obj2.color : obj1.color;
    assign pixelWrite = owner ? obj2.write : obj1.write;

    assign drawDone = obj1.done | obj2.done;    // only one drawer is ever busy

endmodule

// ==== hw/vgaDemoTop.sv ====
module vgaDemoTop
    import vgaDemoPkg::*;
#(
    parameter int                    obj1StartX = 320,
    parameter int                    obj1StartY = 240,
    parameter int                    obj2StartX = 160,
    parameter int                    obj2StartY = 150,
    parameter logic [COLOR_BITS-1:0] obj1Color  = 9'b111_000_000,    // red
    parameter logic [COLOR_BITS-1:0] obj2Color  = 9'b000_000_111     // blue
) (
    input  logic                  CLOCK_50,
    input  logic                  rstN,
    input  logic [1:0]            showKeyN,
    input  logic                  ps2Clk,
    input  logic                  ps2Dat,
    output logic [X_BITS-1:0]     pixelX,
    output logic [Y_BITS-1:0]     pixelY,
    output logic [COLOR_BITS-1:0] pixelColor,
    output logic                  pixelWrite,
    output logic [7:0]            leds,
    output logic [6:0]            hex0,
    output logic [6:0]            hex1,
    output logic [6:0]            hex2,
    output logic [6:0]            hex3,
    output logic [6:0]            hex4,
    output logic [6:0]            hex5
);

    logic        strokeValid;
    logic        drawDone;
    frameBytes_t frames;
    logic [1:0]  show;
    logic [1:0]  move;
    logic [1:0]  dir1;
    logic [1:0]  dir2;

    pixelIf obj1Pix ();
    pixelIf obj2Pix ();

    ps2Receiver rx (
        .CLOCK_50   (CLOCK_50),
        .rstN       (rstN),
        .ps2Clk     (ps2Clk),
        .ps2Dat     (ps2Dat),
        .strokeValid(strokeValid),
        .frames     (frames)
    );

    keyCommand cmd (
        .CLOCK_50   (CLOCK_50),
        .rstN       (rstN),
        .showKeyN   (showKeyN),
        .strokeValid(strokeValid),
        .frames     (frames),
        .drawDone   (drawDone),
        .show       (show),
        .move       (move),
        .dir1       (dir1),
        .dir2       (dir2),
        .scancode   (leds)
    );

    objectDrawer #(
        .startX     (obj1StartX),
        .startY     (obj1StartY),
        .spriteColor(obj1Color)
    ) obj1 (
        .CLOCK_50(CLOCK_50),
        .rstN    (rstN),
        .show    (show[0]),
        .move    (move[0]),
        .dir     (dir1),
        .pix     (obj1Pix.objectDrawer)
    );

    objectDrawer #(
        .startX     (obj2StartX),
        .startY     (obj2StartY),
        .spriteColor(obj2Color)
    ) obj2 (
        .CLOCK_50(CLOCK_50),
        .rstN    (rstN),
        .show    (show[1]),
        .move    (move[1]),
        .dir     (dir2),
        .pix     (obj2Pix.objectDrawer)
    );

    pixelArbiter arb (
        .CLOCK_50  (CLOCK_50),
        .rstN      (rstN),
        .show      (show),
        .move      (move),
        .obj1      (obj1Pix.pixelArbiter),
        .obj2      (obj2Pix.pixelArbiter),
        .drawDone  (drawDone),
        .pixelX    (pixelX),
        .pixelY    (pixelY),
        .pixelColor(pixelColor),
        .pixelWrite(pixelWrite)
    );

    hexDisplay hex (
        .frames(frames),
        .hex0  (hex0),
        .hex1  (hex1),
        .hex2  (hex2),
        .hex3  (hex3),
        .hex4  (hex4),
        .hex5  (hex5)
    );

endmodule

// ==== object/objectDrawer.sv ====
module objectDrawer
    import vgaDemoPkg::*;
#(
    parameter int                    startX      = 320,
    parameter int                    startY      = 240,
    parameter logic [COLOR_BITS-1:0] spriteColor = '1
) (
    input  logic         CLOCK_50,
    input  logic         rstN,
    input  logic         show,
    input  logic         move,
    input  logic [1:0]   dir,
    pixelIf.objectDrawer pix
);

    localparam logic [2:0] LOAD       = 3'd0;
    localparam logic [2:0] IDLE       = 3'd1;
    localparam logic [2:0] ERASE      = 3'd2;
    localparam logic [2:0] ERASE_NEXT = 3'd3;
    localparam logic [2:0] STEP       = 3'd4;
    localparam logic [2:0] DRAW       = 3'd5;
    localparam logic [2:0] DRAW_NEXT  = 3'd6;
    localparam logic [2:0] DONE       = 3'd7;

    localparam logic [SPRITE_BITS-1:0] LAST   = '1;
    localparam logic [X_BITS-1:0]      HALF_X = X_BITS'(1 << (SPRITE_BITS - 1));
    localparam logic [Y_BITS-1:0]      HALF_Y = Y_BITS'(1 << (SPRITE_BITS - 1));

    logic [2:0]             state;
    logic [2:0]             nextState;
    logic [X_BITS-1:0]      posX;    // sprite centre
    logic [Y_BITS-1:0]      posY;
    logic [SPRITE_BITS-1:0] row;
    logic [SPRITE_BITS-1:0] col;
    logic                   writeNow;
    logic                   eraseNow;
    logic                   eraseQ;    // lines up with pix.write
    logic [COLOR_BITS-1:0]  romColor;

    always_comb begin
        nextState = state;
        case (state)
            LOAD:       nextState = IDLE;
            IDLE: begin
                if (show) nextState = DRAW;         // just show at current place
                else if (move) nextState = ERASE;
            end
            ERASE:      if (col == LAST) nextState = ERASE_NEXT;
            ERASE_NEXT: nextState = (row == LAST) ? STEP : ERASE;
            STEP:       nextState = DRAW;
            DRAW:       if (col == LAST) nextState = DRAW_NEXT;
            DRAW_NEXT:  nextState = (row == LAST) ? DONE : DRAW;
            DONE:       if (!show) nextState = IDLE;    // hold while button is down
            default:    nextState = LOAD;
        endcase
    end

    always_ff @(posedge CLOCK_50) begin
        if (!rstN) state <= LOAD;
        else state <= nextState;
    end

    // row and column inside the sprite, 16 writes plus one turn cycle per row
    always_ff @(posedge CLOCK_50) begin
        if (!rstN) begin
            row <= '0;
            col <= '0;
        end else begin
            case (state)
                ERASE, DRAW: col <= col + 1'b1;
                ERASE_NEXT, DRAW_NEXT: begin
                    col <= '0;
                    row <= row + 1'b1;    // wraps to 0 after the last row
                end
                default: begin
                    row <= '0;
                    col <= '0;
                end
            endcase
        end
    end

    // position up/down counters, loaded while held in LOAD
    always_ff @(posedge CLOCK_50) begin
        if (state == LOAD) begin
            posX <= X_BITS'(startX);
            posY <= Y_BITS'(startY);
        end else if (state == STEP) begin
            case (dir)
                DIR_LEFT:  posX <= posX - 1'b1;
                DIR_RIGHT: posX <= posX + 1'b1;
                DIR_UP:    posY <= posY - 1'b1;
                default:   posY <= posY + 1'b1;    // DIR_DOWN
            endcase
        end
    end

    assign writeNow = (state == ERASE) || (state == DRAW);
    assign eraseNow = (state == ERASE);

    spriteRom #(
        .spriteColor(spriteColor)
    ) rom (
        .CLOCK_50(CLOCK_50),
        .addr    ({row, col}),
        .color   (romColor)
    );

    // one cycle behind the counters, same as the rom read
    always_ff @(posedge CLOCK_50) begin
        if (!rstN) begin
            pix.write <= 1'b0;
            eraseQ    <= 1'b0;
        end else begin
            pix.write <= writeNow;
            eraseQ    <= eraseNow;
        end
    end

    always_ff @(posedge CLOCK_50) begin
        pix.x <= posX - HALF_X + X_BITS'(col);    // top left corner is centre minus 8
        pix.y <= posY - HALF_Y + Y_BITS'(row);
    end

    assign pix.color = eraseQ ? '0 : romColor;    // background is black
    assign pix.done  = (state == DONE) && !show;

endmodule

// ==== object/spriteRom.sv ====
module spriteRom
    import vgaDemoPkg::*;
#(
    parameter logic [COLOR_BITS-1:0] spriteColor = '1
) (
    input  logic                     CLOCK_50,
    input  logic [2*SPRITE_BITS-1:0] addr,    // {row, col}
    output logic [COLOR_BITS-1:0]    color
);

    localparam int SIDE  = 1 << SPRITE_BITS;
    localparam int DEPTH = SIDE * SIDE;

    // filled circle of diameter SIDE centred between the middle pixels
    function automatic logic [DEPTH-1:0][COLOR_BITS-1:0] buildRom(
        input logic [COLOR_BITS-1:0] fill
    );
        logic [DEPTH-1:0][COLOR_BITS-1:0] romTable;
        int dr;
        int dc;
        for (int r = 0; r < SIDE; r++) begin
            for (int c = 0; c < SIDE; c++) begin
                dr = 2 * r - (SIDE - 1);
                dc = 2 * c - (SIDE - 1);
                romTable[r*SIDE+c] = (dr * dr + dc * dc <= (SIDE - 1) * (SIDE - 1))
                                   ? fill : '0;
            end
        end
        return romTable;
    endfunction

    localparam logic [DEPTH-1:0][COLOR_BITS-1:0] ROM_DATA = buildRom(spriteColor);

    always_ff @(posedge CLOCK_50) begin
        color <= ROM_DATA[addr];    // registered read
    end

endmodule

// ==== ps2/keyCommand.sv ====
module keyCommand
    import vgaDemoPkg::*;
(
    input  logic        CLOCK_50,
    input  logic        rstN,
    input  logic [1:0]  showKeyN,
    input  logic        strokeValid,
    input  frameBytes_t frames,
    input  logic        drawDone,
    output logic [1:0]  show,
    output logic [1:0]  move,
    output logic [1:0]  dir1,
    output logic [1:0]  dir2,
    output logic [7:0]  scancode
);

    localparam logic [1:0] IDLE  = 2'd0;
    localparam logic [1:0] LATCH = 2'd1;
    localparam logic [1:0] STEP  = 2'd2;
    localparam logic [1:0] WAIT  = 2'd3;

    logic [1:0] showMeta;
    logic [1:0] state;
    logic [1:0] nextState;
    keyCode_u   key;

    // buttons are active low, show comes out active high
    always_ff @(posedge CLOCK_50) begin
        if (!rstN) begin
            showMeta <= 2'b00;
            show     <= 2'b00;
        end else begin
            showMeta <= ~showKeyN;
            show     <= showMeta;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            IDLE:  if (strokeValid && frames[2] != BREAK_CODE) nextState = LATCH;
            LATCH: nextState = STEP;
            STEP:  nextState = WAIT;
            WAIT:  if (drawDone) nextState = IDLE;    // strokes here are lost
            default: nextState = IDLE;
        endcase
    end

    always_ff @(posedge CLOCK_50) begin
        if (!rstN) begin
            state   <= IDLE;
            key.raw <= 8'h00;
        end else begin
            state <= nextState;
            if (state == LATCH) key.raw <= frames[2];    // newest byte is the key
        end
    end

    // one-hot pulse toward the selected drawer
    assign move = (state != STEP) ? 2'b00 : (key.obj1.objSel ? 2'b01 : 2'b10);

    assign dir1     = key.obj1.dir;    // a/w/z/s line up with DIR_* directly
    assign scancode = key.raw;

    // object 2 view needs remapping
    always_comb begin
        case ({key.obj2.dirHi, key.obj2.dirLo})
            2'b01:   dir2 = DIR_LEFT;     // d
            2'b11:   dir2 = DIR_RIGHT;    // f
            2'b10:   dir2 = DIR_UP;       // r
            default: dir2 = DIR_DOWN;     // c
        endcase
    end

endmodule

// ==== ps2/ps2Receiver.sv ====
module ps2Receiver
    import vgaDemoPkg::*;
(
    input  logic        CLOCK_50,
    input  logic        rstN,
    input  logic        ps2Clk,
    input  logic        ps2Dat,
    output logic        strokeValid,
    output frameBytes_t frames
);

    localparam int STREAM_BITS = 3 * PS2_FRAME_BITS;    // press, release, press

    logic                   clkMeta;
    logic                   clkSync;
    logic                   clkPrev;
    logic                   datMeta;
    logic                   datSync;
    logic                   clkFall;
    logic                   frameEnd;
    logic [STREAM_BITS-1:0] shiftReg;
    logic [3:0]             bitCount;

    // two flops per line, idle level of the bus is high
    always_ff @(posedge CLOCK_50) begin
        if (!rstN) begin
            clkMeta <= 1'b1;
            clkSync <= 1'b1;
            clkPrev <= 1'b1;
            datMeta <= 1'b1;
            datSync <= 1'b1;
        end else begin
            clkMeta <= ps2Clk;
            clkSync <= clkMeta;
            clkPrev <= clkSync;    // one more stage for edge detect
            datMeta <= ps2Dat;
            datSync <= datMeta;
        end
    end

    assign clkFall = clkPrev & ~clkSync;    // data is valid on the falling edge

    // newest bit enters at the top, so the oldest frame ends up in the low bits
    always_ff @(posedge CLOCK_50) begin
        if (!rstN) begin
            shiftReg <= '0;
        end else if (clkFall) begin
            shiftReg <= {datSync, shiftReg[STREAM_BITS-1:1]};
        end
    end

    // counts bits of the current frame and sits at eleven for one cycle
    always_ff @(posedge CLOCK_50) begin
        if (!rstN || frameEnd) begin
            bitCount <= '0;
        end else if (clkFall) begin
            bitCount <= bitCount + 4'd1;
        end
    end

    assign frameEnd = (bitCount == 4'(PS2_FRAME_BITS));

    // data byte sits right above the start bit of each frame
    always_comb begin
        for (int k = 0; k < 3; k++) begin
            frames[k] = shiftReg[k*PS2_FRAME_BITS+1 +: 8];
        end
    end

    // key repeat gives code/code/code, a real stroke is code/F0/code
    assign strokeValid = frameEnd && (frames[2] == frames[0]);

endmodule

// ==== tb/pixelBus_properties.sv ====
module pixelBusProperties
    import vgaDemoPkg::*;
#(
    parameter logic [COLOR_BITS-1:0] obj1Color = '1,
    parameter logic [COLOR_BITS-1:0] obj2Color = '1
) (
    input logic                  CLOCK_50,
    input logic                  rstN,
    input logic [X_BITS-1:0]     pixelX,
    input logic [Y_BITS-1:0]     pixelY,
    input logic [COLOR_BITS-1:0] pixelColor,
    input logic                  pixelWrite,
    input logic [7:0]            leds
);

    localparam int SCREEN_W = 640;
    localparam int SCREEN_H = 480;

    int failCount = 0;    // assertion failures seen so far

    // drawers need a few cycles before the first pipelined write
    quietAfterReset: assert property (@(posedge CLOCK_50) $rose(rstN) |-> !pixelWrite [*3])
        else begin
            failCount++;
            $error("pixel write within three cycles of reset release");
        end

    writeLowInReset: assert property (@(posedge CLOCK_50) !rstN |=> !pixelWrite)
        else begin
            failCount++;
            $error("pixel write still high after a reset cycle");
        end

    ledsClearInReset: assert property (@(posedge CLOCK_50) !rstN |=> leds == 8'h00)
        else begin
            failCount++;
            $error("scancode LEDs not cleared by reset");
        end

    // erase writes black, draws write one of the sprite colours or the corner black
    colorLegal: assert property (@(posedge CLOCK_50) disable iff (!rstN)
        pixelWrite |-> (pixelColor == '0 || pixelColor == obj1Color || pixelColor == obj2Color))
        else begin
            failCount++;
            $error("written colour is not black or a sprite colour");
        end

    writeOnScreen: assert property (@(posedge CLOCK_50) disable iff (!rstN)
        pixelWrite |-> (!$isunknown({pixelX, pixelY, pixelColor})
                        && pixelX < SCREEN_W && pixelY < SCREEN_H))
        else begin
            failCount++;
            $error("pixel write off screen or with unknown bits");
        end

endmodule

// ==== tb/tbVgaDemo.sv ====
module tbVgaDemo;
    import vgaDemoPkg::*;

    localparam logic [COLOR_BITS-1:0] OBJ1_COLOR = 9'b111_000_000;    // top level defaults
    localparam logic [COLOR_BITS-1:0] OBJ2_COLOR = 9'b000_000_111;
    localparam int FRAME_CYCLES    = PS2_FRAME_BITS * 16 + 20;    // 11 bits plus longest gap
    localparam int DRAW_CYCLES     = 600;
    localparam int WATCHDOG_CYCLES = 2 * (17 * FRAME_CYCLES + 5 * DRAW_CYCLES);

    logic                  CLOCK_50;
    logic                  rstN;
    logic [1:0]            showKeyN;
    logic                  ps2Clk;
    logic                  ps2Dat;
    logic [X_BITS-1:0]     pixelX;
    logic [Y_BITS-1:0]     pixelY;
    logic [COLOR_BITS-1:0] pixelColor;
    logic                  pixelWrite;
    logic [7:0]            leds;
    logic [6:0]            hex0;
    logic [6:0]            hex1;
    logic [6:0]            hex2;
    logic [6:0]            hex3;
    logic [6:0]            hex4;
    logic [6:0]            hex5;

    int     errors      = 0;
    int     testsRun    = 0;
    int     testsFailed = 0;
    int     testErrBase = 0;
    int     strokeCount = 0;
    int     strokeBase  = 0;
    integer seed        = 55617;
    int     capX[$];    // captured writes of the running test
    int     capY[$];
    int     capC[$];
    time    capT[$];

    vgaDemoTop dut (.*);

    bind vgaDemoTop pixelBusProperties #(
        .obj1Color(obj1Color),
        .obj2Color(obj2Color)
    ) props (.CLOCK_50(CLOCK_50), .rstN(rstN), .pixelX(pixelX), .pixelY(pixelY),
             .pixelColor(pixelColor), .pixelWrite(pixelWrite), .leds(leds));

    initial begin
        CLOCK_50 = 1'b0;
        forever #10 CLOCK_50 = ~CLOCK_50;
    end

    // sample in the middle of the cycle where outputs are stable
    always @(negedge CLOCK_50) begin
        if (pixelWrite === 1'b1) begin
            capX.push_back(pixelX);
            capY.push_back(pixelY);
            capC.push_back(pixelColor);
            capT.push_back($time);
        end
        if (dut.strokeValid === 1'b1) strokeCount++;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge CLOCK_50);
        $display("timeout: run still busy after %0d clock cycles", WATCHDOG_CYCLES);
        $display("Test failures found");
        $finish;
    end

    function automatic bit inCircle(input int r, input int c);
        return (2*r - 15) * (2*r - 15) + (2*c - 15) * (2*c - 15) <= 225;
    endfunction

    // active high gfedcba table inverted for the board
    function automatic logic [6:0] segExpected(input logic [3:0] v);
        logic [6:0] lit;
        case (v)
            4'h0: lit = 7'h3F;
            4'h1: lit = 7'h06;
            4'h2: lit = 7'h5B;
            4'h3: lit = 7'h4F;
            4'h4: lit = 7'h66;
            4'h5: lit = 7'h6D;
            4'h6: lit = 7'h7D;
            4'h7: lit = 7'h07;
            4'h8: lit = 7'h7F;
            4'h9: lit = 7'h6F;
            4'hA: lit = 7'h77;
            4'hB: lit = 7'h7C;
            4'hC: lit = 7'h39;
            4'hD: lit = 7'h5E;
            4'hE: lit = 7'h79;
            default: lit = 7'h71;
        endcase
        return ~lit;
    endfunction

    task automatic tick(input int n);
        repeat (n) @(posedge CLOCK_50);
        #2;    // drive just after the edge
    endtask

    task automatic expectEq(input string name, input int got, input int exp, input time t);
        assert (got == exp) else begin
            $display("mismatch at %0t: %s got %0d expected %0d", t, name, got, exp);
            errors++;
        end
    endtask

    task automatic sendFrame(input logic [7:0] data);
        logic [10:0] bits;
        int          gap;
        bits = {1'b1, ~^data, data, 1'b0};    // stop, odd parity, data lsb first, start
        for (int i = 0; i < PS2_FRAME_BITS; i++) begin
            ps2Dat = bits[i];
            tick(8);
            ps2Clk = 1'b0;    // receiver takes the bit here
            tick(8);
            ps2Clk = 1'b1;
        end
        gap = 4 + ($unsigned($random(seed)) % 16);
        tick(gap);
    endtask

    task automatic sendStroke(input logic [7:0] a, input logic [7:0] b, input logic [7:0] c);
        sendFrame(a);
        sendFrame(b);
        sendFrame(c);
    endtask

    task automatic waitWrites(input int target, input int limit);
        int waited;
        waited = 0;
        while (capX.size() < target && waited < limit) begin
            tick(1);
            waited++;
        end
        if (capX.size() < target) begin
            $display("timeout at %0t: only %0d of %0d pixel writes arrived",
                     $time, capX.size(), target);
            errors++;
        end
        tick(40);    // room for the done pulse and FSM return so extra writes show up
    endtask

    // 16x16 pass from capture index first where colour 0 means erase
    task automatic checkSprite(input int first, input int cx, input int cy, input int colr);
        int r;
        int c;
        int k;
        for (int i = 0; i < 256; i++) begin
            k = first + i;
            r = i / 16;
            c = i % 16;
            if (k < capX.size()) begin
                expectEq("pixelX", capX[k], cx - 8 + c, capT[k]);
                expectEq("pixelY", capY[k], cy - 8 + r, capT[k]);
                expectEq("pixelColor", capC[k], inCircle(r, c) ? colr : 0, capT[k]);
            end
        end
    endtask

    task automatic checkHex(input logic [7:0] oldest, input logic [7:0] middle,
                            input logic [7:0] newest);
        expectEq("hex0", hex0, segExpected(oldest[3:0]), $time);
        expectEq("hex1", hex1, segExpected(oldest[7:4]), $time);
        expectEq("hex2", hex2, segExpected(middle[3:0]), $time);
        expectEq("hex3", hex3, segExpected(middle[7:4]), $time);
        expectEq("hex4", hex4, segExpected(newest[3:0]), $time);
        expectEq("hex5", hex5, segExpected(newest[7:4]), $time);
    endtask

    task automatic beginTest();
        capX.delete();
        capY.delete();
        capC.delete();
        capT.delete();
        testErrBase = errors + dut.props.failCount;
    endtask

    task automatic endTest(input string name);
        int failures;
        failures = errors + dut.props.failCount;
        testsRun++;
        if (failures != testErrBase) testsFailed++;
        $display("test %0d %s: %s", testsRun, name,
                 (failures == testErrBase) ? "ok" : "FAILED");
    endtask

    initial begin
        rstN     = 1'b0;
        showKeyN = 2'b11;    // buttons released
        ps2Clk   = 1'b1;     // bus idle
        ps2Dat   = 1'b1;
        tick(3);
        rstN = 1'b1;

        beginTest();
        tick(50);
        expectEq("write count", capX.size(), 0, $time);
        expectEq("leds", leds, 0, $time);
        endTest("quiet after reset");

        beginTest();
        showKeyN = 2'b10;    // show object 1
        waitWrites(256, DRAW_CYCLES);
        showKeyN = 2'b11;
        tick(20);
        expectEq("write count", capX.size(), 256, $time);
        checkSprite(0, 320, 240, OBJ1_COLOR);
        endTest("show object 1");

        beginTest();
        sendStroke(8'h23, BREAK_CODE, 8'h23);    // d moves object 2 left
        waitWrites(512, 2 * DRAW_CYCLES);
        expectEq("write count", capX.size(), 512, $time);
        checkSprite(0, 160, 150, 0);
        checkSprite(256, 159, 150, OBJ2_COLOR);
        expectEq("leds", leds, 8'h23, $time);
        checkHex(8'h23, BREAK_CODE, 8'h23);
        endTest("object 2 left on d");

        beginTest();
        sendStroke(8'h1B, BREAK_CODE, 8'h1B);    // s moves object 1 right
        waitWrites(512, 2 * DRAW_CYCLES);
        expectEq("write count", capX.size(), 512, $time);
        checkSprite(0, 320, 240, 0);
        checkSprite(256, 321, 240, OBJ1_COLOR);
        endTest("object 1 right on s");

        beginTest();
        sendStroke(8'h1B, BREAK_CODE, 8'h1C);    // oldest and newest differ
        tick(DRAW_CYCLES);
        expectEq("write count", capX.size(), 0, $time);
        expectEq("leds", leds, 8'h1B, $time);
        sendStroke(8'h1C, BREAK_CODE, 8'h1C);    // a brings object 1 back
        waitWrites(512, 2 * DRAW_CYCLES);
        expectEq("write count", capX.size(), 512, $time);
        checkSprite(0, 321, 240, 0);
        checkSprite(256, 320, 240, OBJ1_COLOR);
        endTest("broken stroke ignored");

        beginTest();
        strokeBase = strokeCount;
        sendStroke(8'h23, BREAK_CODE, 8'h23);
        sendFrame(BREAK_CODE);    // F0/d/F0 also matches and the break check rejects it
        sendFrame(8'h23);         // d/F0/d again while object 2 redraws
        waitWrites(512, 2 * DRAW_CYCLES);
        tick(DRAW_CYCLES);
        expectEq("write count", capX.size(), 512, $time);
        expectEq("stroke count", strokeCount - strokeBase, 3, $time);
        checkSprite(0, 159, 150, 0);
        checkSprite(256, 158, 150, OBJ2_COLOR);
        endTest("stroke dropped while busy");

        $display("tests %0d, failed %0d, check errors %0d, assertion failures %0d",
                 testsRun, testsFailed, errors, dut.props.failCount);
        if (errors == 0 && dut.props.failCount == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
common/vgaDemoPkg.sv
common/pixelIf.sv
ps2/ps2Receiver.sv
ps2/keyCommand.sv
object/spriteRom.sv
object/objectDrawer.sv
hw/pixelArbiter.sv
hw/hexDisplay.sv
hw/vgaDemoTop.sv
tb/pixelBus_properties.sv
tb/tbVgaDemo.sv
